//--- hw/march_engine.sv
/*
 * march engine for one RAM port
 * pass 0 walks offsets up, pass 1 walks them down, pages ascend in both,
 * each page written with offset ^ key and read back in the same order
 */
`timescale 1ns/1ps

module march_engine #(
	parameter int channel = 0
) (
	input  logic clk,
	input  logic n_reset,
	input  logic go,
	input  psram_pkg::ram_page_t last_page,
	input  psram_pkg::ram_rsp_t rsp,
	input  logic report_busy,
	output psram_pkg::ram_req_t req,
	output logic msg_valid,
	output report_pkg::report_msg_t msg,
	output logic done
);
	typedef enum logic [3:0] {
		s_idle,
		s_wr,
		s_wr_gap,
		s_rd_gap,
		s_rd,
		s_rd_wait,
		s_cmp,
		s_report,
		s_report_wait
	} state_e;

	state_e state;
	logic pass;
	logic fail;
	logic [3:0] cnt;
	psram_pkg::ram_addr_u addr;
	logic [7:0] rdata_q;
	logic [7:0] pattern;
	logic [7:0] start_offset;
	logic [7:0] end_offset;
	logic [7:0] next_offset;
	logic rd_open;

	// offset walk direction depends on the pass
	assign start_offset = pass ? 8'hff : 8'h00;
	assign end_offset = pass ? 8'h00 : 8'hff;
	assign next_offset = pass ? addr.field.offset - 8'd1 : addr.field.offset + 8'd1;
	assign pattern = addr.field.offset ^ psram_pkg::c_pattern_key;

	always_comb
	begin
		req.rd = (state == s_rd);
		req.wr = (state == s_wr);
		req.address = addr;
		req.wdata = pattern;
	end

	assign msg_valid = (state == s_report) && !report_busy;

	always_comb
	begin
		msg.kind = fail ? report_pkg::msg_ng : report_pkg::msg_ok;
		msg.channel = 1'(channel);
		msg.address = addr;
		msg.rdata = rdata_q;
	end

	always_ff @(posedge clk)
	begin
		if (state == s_rd_wait && rsp.rdata_en)
			rdata_q <= rsp.rdata;
	end

	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state <= s_idle;
			pass <= 1'b0;
			fail <= 1'b0;
			cnt <= '0;
			addr <= '0;
			done <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			case (state)
			s_idle:
				if (go)
				begin
					pass <= 1'b0;
					fail <= 1'b0;
					addr.flat <= '0;
					state <= s_wr;
				end
			// ----------------------------------------
			// write sweep
			// ----------------------------------------
			s_wr:
			begin
				cnt <= 4'(psram_pkg::c_wr_wait - 1);
				state <= s_wr_gap;
			end
			s_wr_gap:
				if (cnt != '0)
					cnt <= cnt - 4'd1;
				else if (addr.field.offset == end_offset)
				begin
					addr.field.offset <= start_offset;
					cnt <= 4'(psram_pkg::c_rd_wait - 1);
					state <= s_rd_gap;
				end
				else
				begin
					addr.field.offset <= next_offset;
					state <= s_wr;
				end
			// ----------------------------------------
			// read-back sweep
			// ----------------------------------------
			s_rd_gap:
				if (cnt != '0)
					cnt <= cnt - 4'd1;
				else
					state <= s_rd;
			s_rd:
				state <= s_rd_wait;
			s_rd_wait:
				if (rsp.rdata_en)
					state <= s_cmp;
			s_cmp:
				if (rdata_q != pattern)
				begin
					// addr and rdata_q now hold the failing access
					fail <= 1'b1;
					state <= s_report;
				end
				else if (addr.field.offset != end_offset)
				begin
					addr.field.offset <= next_offset;
					cnt <= 4'(psram_pkg::c_rd_wait - 1);
					state <= s_rd_gap;
				end
				else if (addr.field.page == last_page)
					state <= s_report;
				else
				begin
					addr.field.page <= addr.field.page + 1'b1;
					addr.field.offset <= start_offset;
					state <= s_wr;
				end
			// ----------------------------------------
			// pass result
			// ----------------------------------------
			s_report:
				if (msg_valid)
					state <= s_report_wait;
			s_report_wait:
				if (!report_busy)
				begin
					if (!pass)
					begin
						pass <= 1'b1;
						fail <= 1'b0;
						addr.field.page <= '0;
						addr.field.offset <= '1;
						state <= s_wr;
					end
					else
					begin
						done <= 1'b1;
						state <= s_idle;
					end
				end
			default:
				state <= s_idle;
			endcase
		end
	end

	// read outstanding between the rd strobe and rdata_en
	always_ff @(posedge clk)
	begin
		if (!n_reset)
			rd_open <= 1'b0;
		else if (rsp.rdata_en)
			rd_open <= 1'b0;
		else if (req.rd)
			rd_open <= 1'b1;
	end

	a_rd_wr_excl: assert property (@(posedge clk) disable iff (!n_reset)
		!(req.rd && req.wr));

	a_one_read: assert property (@(posedge clk) disable iff (!n_reset)
		rd_open |-> !(req.rd || req.wr));

endmodule

//--- hw/psram_pkg.sv
/*
 * psram memory-side definitions
 * address layout, RAM port request/response, access timing and pattern
 */

package psram_pkg;

	// ----------------------------------------
	// geometry
	// ----------------------------------------
	localparam int c_ram_count = 2;
	localparam int c_page_bits = 14;
	localparam int c_offset_bits = 8;
	localparam int c_addr_bits = c_page_bits + c_offset_bits;

	typedef logic [c_page_bits-1:0] ram_page_t;

	// page in the upper bits, byte offset in the lower bits
	typedef struct packed {
		ram_page_t page;
		logic [c_offset_bits-1:0] offset;
	} ram_addr_s;

	typedef union packed {
		logic [c_addr_bits-1:0] flat;
		ram_addr_s field;
	} ram_addr_u;

	// ----------------------------------------
	// RAM port
	// ----------------------------------------
	typedef struct packed {
		logic rd;
		logic wr;
		ram_addr_u address;
		logic [7:0] wdata;
	} ram_req_t;

	typedef struct packed {
		logic [7:0] rdata;
		logic rdata_en;
		logic busy;
	} ram_rsp_t;

	// idle cycles around accesses
	localparam int c_wr_wait = 13;
	localparam int c_rd_wait = 3;

	localparam logic [7:0] c_pattern_key = 8'h9c;
	localparam int c_settle_cycles = 16;

endpackage

//--- hw/psram_test_top.sv
/*
 * PSRAM built-in test, top level
 * sequencer, one march engine per RAM port and the UART report writer
 */
`timescale 1ns/1ps

module psram_test_top (
	input  logic clk,
	input  logic n_reset,
	input  logic start,
	input  psram_pkg::ram_page_t last_page,
	input  psram_pkg::ram_rsp_t ram_rsp [psram_pkg::c_ram_count],
	output psram_pkg::ram_req_t ram_req [psram_pkg::c_ram_count],
	output logic [7:0] send_data,
	output logic send_req,
	input  logic send_busy,
	output logic finished
);
	logic [psram_pkg::c_ram_count-1:0] ram_busy;
	logic [psram_pkg::c_ram_count-1:0] engine_go;
	logic [psram_pkg::c_ram_count-1:0] engine_done;
	logic [psram_pkg::c_ram_count:0] src_valid;
	report_pkg::report_msg_t src_msg [psram_pkg::c_ram_count+1];
	logic report_busy;

	// sequencer owns the last report slot
	test_sequencer u_sequencer (
		.clk(clk),
		.n_reset(n_reset),
		.start(start),
		.ram_busy(ram_busy),
		.report_busy(report_busy),
		.engine_done(engine_done),
		.engine_go(engine_go),
		.msg_valid(src_valid[psram_pkg::c_ram_count]),
		.msg(src_msg[psram_pkg::c_ram_count]),
		.finished(finished)
	);

	for (genvar g = 0; g < psram_pkg::c_ram_count; g++)
	begin : g_engine
		assign ram_busy[g] = ram_rsp[g].busy;

		march_engine #(
			.channel(g)
		) u_engine (
			.clk(clk),
			.n_reset(n_reset),
			.go(engine_go[g]),
			.last_page(last_page),
			.rsp(ram_rsp[g]),
			.report_busy(report_busy),
			.req(ram_req[g]),
			.msg_valid(src_valid[g]),
			.msg(src_msg[g]),
			.done(engine_done[g])
		);
	end

	report_writer u_writer (
		.clk(clk),
		.n_reset(n_reset),
		.src_valid(src_valid),
		.src_msg(src_msg),
		.send_busy(send_busy),
		.report_busy(report_busy),
		.send_data(send_data),
		.send_req(send_req)
	);

endmodule

//--- hw/report_pkg.sv
/*
 * report-side definitions
 * message kinds, the message record and the ASCII codes used in the text
 */

package report_pkg;

	typedef enum logic [2:0] {
		msg_banner,
		msg_ready,
		msg_channel,
		msg_ok,
		msg_ng
	} msg_kind_e;

	// one report line, address and rdata only matter for msg_ng
	typedef struct packed {
		msg_kind_e kind;
		logic channel;
		psram_pkg::ram_addr_u address;
		logic [7:0] rdata;
	} report_msg_t;

	// ----------------------------------------
	// ASCII
	// ----------------------------------------
	localparam logic [7:0] c_char_cr = 8'h0d;
	localparam logic [7:0] c_char_lf = 8'h0a;
	localparam logic [7:0] c_char_sp = 8'h20;
	localparam logic [7:0] c_char_0 = 8'h30;
	localparam logic [7:0] c_char_a = 8'h41;
	localparam logic [7:0] c_char_e = 8'h45;
	localparam logic [7:0] c_char_g = 8'h47;
	localparam logic [7:0] c_char_k = 8'h4b;
	localparam logic [7:0] c_char_m = 8'h4d;
	localparam logic [7:0] c_char_n = 8'h4e;
	localparam logic [7:0] c_char_o = 8'h4f;
	localparam logic [7:0] c_char_p = 8'h50;
	localparam logic [7:0] c_char_r = 8'h52;
	localparam logic [7:0] c_char_s = 8'h53;
	localparam logic [7:0] c_char_t = 8'h54;

endpackage

//--- hw/report_writer.sv
/*
 * report writer
 * latches one report message and sends its text to the UART char by char
 */
`timescale 1ns/1ps

module report_writer (
	input  logic clk,
	input  logic n_reset,
	input  logic [psram_pkg::c_ram_count:0] src_valid,
	input  report_pkg::report_msg_t src_msg [psram_pkg::c_ram_count+1],
	input  logic send_busy,
	output logic report_busy,
	output logic [7:0] send_data,
	output logic send_req
);
	report_pkg::report_msg_t sel_msg;
	report_pkg::report_msg_t msg_q;
	logic [3:0] idx;

	// uppercase hex digit
	function automatic logic [7:0] bin2hex(input logic [3:0] d);
		logic [7:0] c;
		if (d < 4'd10)
			c = report_pkg::c_char_0 + {4'd0, d};
		else
			c = report_pkg::c_char_a + {4'd0, d} - 8'd10;
		return c;
	endfunction

	// text of each kind, every line ends in LF
	function automatic logic [7:0] char_at(input report_pkg::report_msg_t m,
		input logic [3:0] i);
		logic [21:0] a;
		logic [7:0] c;
		a = m.address.flat;
		c = report_pkg::c_char_lf;
		case (m.kind)
		report_pkg::msg_banner:
			case (i)
			4'd0: c = report_pkg::c_char_p;
			4'd1: c = report_pkg::c_char_s;
			4'd2: c = report_pkg::c_char_r;
			4'd3: c = report_pkg::c_char_a;
			4'd4: c = report_pkg::c_char_m;
			4'd5: c = report_pkg::c_char_sp;
			4'd6: c = report_pkg::c_char_t;
			4'd7: c = report_pkg::c_char_e;
			4'd8: c = report_pkg::c_char_s;
			4'd9: c = report_pkg::c_char_t;
			4'd10: c = report_pkg::c_char_cr;
			default: c = report_pkg::c_char_lf;
			endcase
		report_pkg::msg_channel:
			case (i)
			4'd0: c = report_pkg::c_char_r;
			4'd1: c = report_pkg::c_char_a;
			4'd2: c = report_pkg::c_char_m;
			4'd3: c = bin2hex({3'd0, m.channel});
			4'd4: c = report_pkg::c_char_cr;
			default: c = report_pkg::c_char_lf;
			endcase
		report_pkg::msg_ng:
			case (i)
			4'd0: c = report_pkg::c_char_n;
			4'd1: c = report_pkg::c_char_g;
			4'd2: c = bin2hex({2'd0, a[21:20]});
			4'd3: c = bin2hex(a[19:16]);
			4'd4: c = bin2hex(a[15:12]);
			4'd5: c = bin2hex(a[11:8]);
			4'd6: c = bin2hex(a[7:4]);
			4'd7: c = bin2hex(a[3:0]);
			4'd8: c = report_pkg::c_char_sp;
			4'd9: c = bin2hex(m.rdata[7:4]);
			4'd10: c = bin2hex(m.rdata[3:0]);
			4'd11: c = report_pkg::c_char_cr;
			default: c = report_pkg::c_char_lf;
			endcase
		// ready and ok share "OK"
		default:
			case (i)
			4'd0: c = report_pkg::c_char_o;
			4'd1: c = report_pkg::c_char_k;
			4'd2: c = report_pkg::c_char_cr;
			default: c = report_pkg::c_char_lf;
			endcase
		endcase
		return c;
	endfunction

	always_comb
	begin
		sel_msg = src_msg[0];
		for (int i = 0; i <= psram_pkg::c_ram_count; i++)
			if (src_valid[i])
				sel_msg = src_msg[i];
	end

	assign send_data = char_at(msg_q, idx);

	always_ff @(posedge clk)
	begin
		if (!report_busy && (src_valid != '0))
			msg_q <= sel_msg;
	end

	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			report_busy <= 1'b0;
			send_req <= 1'b0;
			idx <= '0;
		end
		else if (!report_busy)
		begin
			if (src_valid != '0)
			begin
				report_busy <= 1'b1;
				send_req <= 1'b1;
				idx <= '0;
			end
		end
		else if (send_req)
		begin
			// character taken, drop req for one cycle
			if (!send_busy)
			begin
				send_req <= 1'b0;
				if (send_data == report_pkg::c_char_lf)
					report_busy <= 1'b0;
				else
					idx <= idx + 4'd1;
			end
		end
		else
			send_req <= 1'b1;
	end

	a_one_source: assert property (@(posedge clk) disable iff (!n_reset)
		$onehot0(src_valid));

endmodule

//--- hw/test_sequencer.sv
/*
 * test sequencer
 * banner, wait for the RAMs, settle, then one engine per channel in turn
 */
`timescale 1ns/1ps

module test_sequencer (
	input  logic clk,
	input  logic n_reset,
	input  logic start,
	input  logic [psram_pkg::c_ram_count-1:0] ram_busy,
	input  logic report_busy,
	input  logic [psram_pkg::c_ram_count-1:0] engine_done,
	output logic [psram_pkg::c_ram_count-1:0] engine_go,
	output logic msg_valid,
	output report_pkg::report_msg_t msg,
	output logic finished
);
	typedef enum logic [2:0] {
		s_idle,
		s_banner,
		s_ram_wait,
		s_settle,
		s_channel,
		s_go,
		s_run
	} state_e;

	state_e state;
	logic ch;
	logic [4:0] cnt;

	// message strobes straight from the state, only while the writer is free
	always_comb
	begin
		msg_valid = 1'b0;
		msg = '0;
		msg.channel = ch;
		case (state)
		s_banner:
		begin
			msg.kind = report_pkg::msg_banner;
			msg_valid = !report_busy;
		end
		s_ram_wait:
		begin
			msg.kind = report_pkg::msg_ready;
			msg_valid = !report_busy && (ram_busy == '0);
		end
		s_channel:
		begin
			msg.kind = report_pkg::msg_channel;
			msg_valid = !report_busy;
		end
		default:
		begin
			msg.kind = report_pkg::msg_ok;
		end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!n_reset)
		begin
			state <= s_idle;
			ch <= 1'b0;
			cnt <= '0;
			engine_go <= '0;
			finished <= 1'b0;
		end
		else
		begin
			engine_go <= '0;
			case (state)
			s_idle:
				if (start)
				begin
					finished <= 1'b0;
					ch <= 1'b0;
					state <= s_banner;
				end
			s_banner:
				if (msg_valid)
					state <= s_ram_wait;
			s_ram_wait:
				if (msg_valid)
				begin
					cnt <= '0;
					state <= s_settle;
				end
			// settle time counts once the ready line is out
			s_settle:
				if (!report_busy)
				begin
					if (cnt == 5'(psram_pkg::c_settle_cycles - 1))
						state <= s_channel;
					else
						cnt <= cnt + 5'd1;
				end
			s_channel:
				if (msg_valid)
					state <= s_go;
			s_go:
				if (!report_busy)
				begin
					engine_go[ch] <= 1'b1;
					state <= s_run;
				end
			s_run:
				if (engine_done[ch])
				begin
					if (ch == 1'(psram_pkg::c_ram_count - 1))
					begin
						finished <= 1'b1;
						state <= s_idle;
					end
					else
					begin
						ch <= ch + 1'b1;
						state <= s_channel;
					end
				end
			default:
				state <= s_idle;
			endcase
		end
	end

	// the channel header must be fully out before its engine starts
	a_go_idle: assert property (@(posedge clk) disable iff (!n_reset)
		(engine_go != '0) |-> !report_busy);

endmodule

//--- list.f
hw/psram_pkg.sv
hw/report_pkg.sv
hw/test_sequencer.sv
hw/march_engine.sv
hw/report_writer.sv
hw/psram_test_top.sv
tests/psram_model.sv
tests/tb_psram_test.sv

//--- run_sim.sh
#!/bin/sh
# build and run the PSRAM test simulation with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module tb_psram_test -Mdir obj_dir -f list.f
./obj_dir/Vtb_psram_test > sim.log 2>&1 || true
cat sim.log
if grep -q "TESTS FAILED" sim.log; then
	echo "simulation failed"
	exit 1
fi
if ! grep -q "TESTS PASSED" sim.log; then
	echo "simulation ended without a result"
	exit 1
fi
echo "simulation passed"

//--- tests/psram_model.sv
/*
 * behavioral PSRAM model
 * byte memory with random read latency, busy after reset and one stuck bit
 */
`timescale 1ns/1ps

module psram_model #(
	parameter logic [31:0] seed = 32'ha47
) (
	input  logic clk,
	input  logic n_reset,
	input  psram_pkg::ram_req_t req,
	output psram_pkg::ram_rsp_t rsp,
	input  logic hold_busy,
	input  logic stuck_en,
	input  psram_pkg::ram_addr_u stuck_addr,
	input  logic [2:0] stuck_bit,
	input  logic stuck_val
);
	logic [7:0] mem [logic [21:0]];
	logic [31:0] rng;
	logic [4:0] busy_cnt;
	logic [2:0] delay;
	logic pending;
	psram_pkg::ram_addr_u rd_addr;
	logic [7:0] rdata_q;
	logic rdata_en_q;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// bytes never written read back as a mix of the whole address
	function automatic logic [7:0] read_byte(input psram_pkg::ram_addr_u a);
		logic [7:0] d;
		if (mem.exists(a.flat))
			d = mem[a.flat];
		else
			d = a.flat[7:0] ^ a.flat[15:8] ^ {2'b0, a.flat[21:16]};
		if (stuck_en && a.flat == stuck_addr.flat)
			d[stuck_bit] = stuck_val;
		return d;
	endfunction

	always @(posedge clk)
	begin
		rdata_en_q <= 1'b0;
		if (!n_reset)
		begin
			busy_cnt <= 5'd20;
			pending <= 1'b0;
			rng <= seed;
		end
		else
		begin
			if (busy_cnt != 5'd0)
				busy_cnt <= busy_cnt - 5'd1;
			if (req.wr)
				mem[req.address.flat] = req.wdata;
			// rdata_en comes 2 to 5 cycles after the rd strobe
			if (req.rd)
			begin
				rng <= xorshift32(rng);
				delay <= {1'b0, rng[1:0]};
				rd_addr <= req.address;
				pending <= 1'b1;
			end
			else if (pending)
			begin
				if (delay == 3'd0)
				begin
					rdata_en_q <= 1'b1;
					rdata_q <= read_byte(rd_addr);
					pending <= 1'b0;
				end
				else
					delay <= delay - 3'd1;
			end
		end
	end

	always_comb
	begin
		rsp.rdata = rdata_q;
		rsp.rdata_en = rdata_en_q;
		rsp.busy = (busy_cnt != 5'd0) || hold_busy;
	end

endmodule

//--- tests/tb_psram_test.sv
/*
 * testbench for the PSRAM built-in test
 * two RAM models, a UART sink with random back-pressure, directed tests
 */
`timescale 1ns/1ps

module tb_psram_test;
	logic clk = 1'b0;
	logic n_reset;
	logic start;
	psram_pkg::ram_page_t last_page;
	psram_pkg::ram_rsp_t ram_rsp [psram_pkg::c_ram_count];
	psram_pkg::ram_req_t ram_req [psram_pkg::c_ram_count];
	logic [7:0] send_data;
	logic send_req;
	logic send_busy = 1'b0;
	logic finished;

	logic [psram_pkg::c_ram_count-1:0] hold_busy;
	logic [psram_pkg::c_ram_count-1:0] stuck_en;
	psram_pkg::ram_addr_u stuck_addr;
	logic [2:0] stuck_bit;
	logic stuck_val;

	// uart sink and captured text
	logic [31:0] rng = 32'ha47;
	int stretch = 0;
	bit heavy = 1'b0;
	string cur_line;
	logic [7:0] prev_char;
	string lines[$];
	string exp_lines[$];

	// access monitor
	bit watch = 1'b0;
	int idle_after_wr [psram_pkg::c_ram_count];
	int idle_after_en [psram_pkg::c_ram_count];
	bit rd_open [psram_pkg::c_ram_count];
	bit reading [psram_pkg::c_ram_count];
	int wr_count [psram_pkg::c_ram_count];
	psram_pkg::ram_addr_u wr_queue[$];

	always #5 clk = ~clk;

	psram_test_top uut (
		.clk(clk),
		.n_reset(n_reset),
		.start(start),
		.last_page(last_page),
		.ram_rsp(ram_rsp),
		.ram_req(ram_req),
		.send_data(send_data),
		.send_req(send_req),
		.send_busy(send_busy),
		.finished(finished)
	);

	for (genvar g = 0; g < psram_pkg::c_ram_count; g++)
	begin : g_ram
		psram_model #(
			.seed(32'ha47)
		) u_ram (
			.clk(clk),
			.n_reset(n_reset),
			.req(ram_req[g]),
			.rsp(ram_rsp[g]),
			.hold_busy(hold_busy[g]),
			.stuck_en(stuck_en[g]),
			.stuck_addr(stuck_addr),
			.stuck_bit(stuck_bit),
			.stuck_val(stuck_val)
		);
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// uppercase hex text of the low digits of v
	function automatic string hex_text(input logic [23:0] v, input int digits);
		string table_s;
		string s;
		logic [3:0] d;
		table_s = "0123456789ABCDEF";
		s = "";
		for (int i = digits - 1; i >= 0; i--)
		begin
			d = v[i*4 +: 4];
			s = $sformatf("%s%c", s, table_s.getc(int'(d)));
		end
		return s;
	endfunction

	task automatic fail_run(input string reason);
		$display("%s", reason);
		$display("TESTS FAILED");
		$fatal(1);
	endtask

	// ----------------------------------------
	// compare tasks
	// ----------------------------------------
	task automatic check_line(input string got, input string exp, input string name);
		if (got != exp)
			fail_run($sformatf("** Error at %0t: %s = \"%s\", expected \"%s\"",
				$time, name, got, exp));
	endtask

	task automatic check_addr(input psram_pkg::ram_addr_u got,
		input psram_pkg::ram_addr_u exp, input string name);
		if (got.flat != exp.flat)
			fail_run($sformatf("** Error at %0t: %s = %06h, expected %06h",
				$time, name, got.flat, exp.flat));
	endtask

	task automatic check_byte(input logic [7:0] got, input logic [7:0] exp, input string name);
		if (got != exp)
			fail_run($sformatf("** Error at %0t: %s = %02h, expected %02h",
				$time, name, got, exp));
	endtask

	// ----------------------------------------
	// uart sink
	// ----------------------------------------
	task automatic take_char(input logic [7:0] c);
		if (prev_char == 8'h0d && c != 8'h0a)
			fail_run("CR inside a report line");
		if (c == 8'h0a)
		begin
			if (prev_char != 8'h0d)
				fail_run("report line not ended by CR LF");
			lines.push_back(cur_line);
			cur_line = "";
		end
		else if (c != 8'h0d)
			cur_line = $sformatf("%s%c", cur_line, c);
		prev_char = c;
	endtask

	// a char is taken when req is high and busy low at the next rising edge
	always @(negedge clk)
	begin
		if (stretch > 0)
			stretch = stretch - 1;
		else
		begin
			rng = xorshift32(rng);
			if (heavy)
			begin
				send_busy = (rng[2:0] != 3'd0);
				stretch = int'(rng[8:4]);
			end
			else
			begin
				send_busy = (rng[1:0] == 2'd0);
				stretch = int'(rng[5:4]);
			end
		end
		if (send_req && !send_busy)
			take_char(send_data);
	end

	// ----------------------------------------
	// access monitor
	// ----------------------------------------
	task automatic watch_port(input int ch);
		psram_pkg::ram_req_t r;
		psram_pkg::ram_rsp_t s;
		psram_pkg::ram_addr_u exp_addr;
		r = ram_req[ch];
		s = ram_rsp[ch];
		if (r.rd && r.wr)
			fail_run($sformatf("rd and wr both high on RAM%0d", ch));
		if ((r.rd || r.wr) && rd_open[ch])
			fail_run($sformatf("RAM%0d access while a read is outstanding", ch));
		if ((r.rd || r.wr) && idle_after_wr[ch] < psram_pkg::c_wr_wait)
			fail_run($sformatf("RAM%0d access too soon after a write", ch));
		if (r.rd && idle_after_en[ch] < psram_pkg::c_rd_wait)
			fail_run($sformatf("RAM%0d read too soon after rdata_en", ch));
		if (r.wr)
		begin
			check_byte(r.wdata, r.address.field.offset ^ psram_pkg::c_pattern_key,
				"ram_req.wdata");
			// a new write sweep starts only after the page was read back
			if (reading[ch] && wr_queue.size() != 0)
				fail_run($sformatf("RAM%0d page not fully read back", ch));
			reading[ch] = 1'b0;
			wr_queue.push_back(r.address);
			wr_count[ch] = wr_count[ch] + 1;
			idle_after_wr[ch] = 0;
		end
		else if (idle_after_wr[ch] < 1000)
			idle_after_wr[ch] = idle_after_wr[ch] + 1;
		if (r.rd)
		begin
			reading[ch] = 1'b1;
			if (wr_queue.size() == 0)
				fail_run($sformatf("RAM%0d read of an address never written", ch));
			exp_addr = wr_queue.pop_front();
			check_addr(r.address, exp_addr, "ram_req.address");
			rd_open[ch] = 1'b1;
		end
		if (s.rdata_en)
		begin
			rd_open[ch] = 1'b0;
			idle_after_en[ch] = 0;
		end
		else if (idle_after_en[ch] < 1000)
			idle_after_en[ch] = idle_after_en[ch] + 1;
	endtask

	always @(negedge clk)
	begin
		if (watch && n_reset)
			for (int ch = 0; ch < psram_pkg::c_ram_count; ch++)
				watch_port(ch);
	end

	task automatic init_monitor();
		for (int ch = 0; ch < psram_pkg::c_ram_count; ch++)
		begin
			idle_after_wr[ch] = 1000;
			idle_after_en[ch] = 1000;
			rd_open[ch] = 1'b0;
			reading[ch] = 1'b0;
			wr_count[ch] = 0;
		end
		wr_queue.delete();
	endtask

	// ----------------------------------------
	// sequencing helpers
	// ----------------------------------------
	task automatic clear_capture();
		lines.delete();
		cur_line = "";
		prev_char = '0;
	endtask

	task automatic apply_reset();
		@(negedge clk);
		n_reset = 1'b0;
		start = 1'b0;
		repeat (10) @(negedge clk);
		n_reset = 1'b1;
		clear_capture();
	endtask

	task automatic start_run();
		@(negedge clk);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (finished)
			fail_run("finished still high after start");
	endtask

	task automatic wait_finished(input int limit);
		int n;
		n = 0;
		while (!finished)
		begin
			@(negedge clk);
			n = n + 1;
			if (n > limit)
				fail_run("timeout waiting for finished");
		end
	endtask

	task automatic wait_lines(input int count, input int limit);
		int n;
		n = 0;
		while (lines.size() < count)
		begin
			@(negedge clk);
			n = n + 1;
			if (n > limit)
				fail_run($sformatf("timeout waiting for report line %0d", count));
		end
	endtask

	task automatic build_clean_text();
		exp_lines.delete();
		exp_lines.push_back("PSRAM TEST");
		exp_lines.push_back("OK");
		for (int ch = 0; ch < psram_pkg::c_ram_count; ch++)
		begin
			exp_lines.push_back($sformatf("RAM%0d", ch));
			exp_lines.push_back("OK");
			exp_lines.push_back("OK");
		end
	endtask

	task automatic check_text();
		if (lines.size() != exp_lines.size())
			fail_run($sformatf("received %0d report lines, expected %0d",
				lines.size(), exp_lines.size()));
		foreach (exp_lines[i])
			check_line(lines[i], exp_lines[i], $sformatf("report line %0d", i));
	endtask

	// ----------------------------------------
	// directed tests
	// ----------------------------------------
	task automatic clean_run();
		apply_reset();
		last_page = 14'd1;
		build_clean_text();
		start_run();
		wait_finished(200000);
		check_text();
		$display("done: clean run");
	endtask

	// RAM1 stays busy well past its reset window
	task automatic ready_after_busy();
		apply_reset();
		last_page = 14'd1;
		hold_busy = 2'b10;
		build_clean_text();
		start_run();
		wait_lines(1, 2000);
		check_line(lines[0], "PSRAM TEST", "banner line");
		repeat (300)
		begin
			@(negedge clk);
			if (lines.size() > 1)
				fail_run("ready line sent while a RAM was busy");
		end
		hold_busy = '0;
		wait_lines(2, 2000);
		wait_finished(200000);
		check_text();
		$display("done: ready after busy");
	endtask

	task automatic stuck_bit_report();
		psram_pkg::ram_addr_u bad;
		logic [7:0] bad_data;
		string ng;
		bad.field.page = 14'd1;
		bad.field.offset = 8'h37;
		bad_data = 8'h37 ^ psram_pkg::c_pattern_key;
		bad_data[2] = 1'b1;
		apply_reset();
		last_page = 14'd1;
		stuck_addr = bad;
		stuck_bit = 3'd2;
		stuck_val = 1'b1;
		stuck_en = 2'b10;
		ng = {"NG", hex_text({2'b00, bad.flat}, 6), " ", hex_text({16'h0, bad_data}, 2)};
		exp_lines.delete();
		exp_lines.push_back("PSRAM TEST");
		exp_lines.push_back("OK");
		exp_lines.push_back("RAM0");
		exp_lines.push_back("OK");
		exp_lines.push_back("OK");
		exp_lines.push_back("RAM1");
		exp_lines.push_back(ng);
		exp_lines.push_back(ng);
		start_run();
		wait_finished(200000);
		check_text();
		stuck_en = '0;
		$display("done: stuck bit report");
	endtask

	task automatic access_discipline();
		apply_reset();
		last_page = 14'd2;
		init_monitor();
		watch = 1'b1;
		build_clean_text();
		start_run();
		wait_finished(300000);
		watch = 1'b0;
		check_text();
		if (wr_queue.size() != 0)
			fail_run("written bytes never read back");
		for (int ch = 0; ch < psram_pkg::c_ram_count; ch++)
			if (wr_count[ch] != 2 * 256 * (int'(last_page) + 1))
				fail_run($sformatf("RAM%0d saw %0d writes, expected %0d", ch,
					wr_count[ch], 2 * 256 * (int'(last_page) + 1)));
		$display("done: access discipline");
	endtask

	task automatic back_pressure_repeat();
		apply_reset();
		last_page = 14'd1;
		heavy = 1'b1;
		build_clean_text();
		start_run();
		wait_finished(400000);
		check_text();
		repeat (20)
		begin
			@(negedge clk);
			if (!finished)
				fail_run("finished dropped without a start");
		end
		clear_capture();
		start_run();
		wait_finished(400000);
		check_text();
		heavy = 1'b0;
		$display("done: back pressure and repeat");
	endtask

	initial
	begin
		n_reset = 1'b0;
		start = 1'b0;
		last_page = '0;
		hold_busy = '0;
		stuck_en = '0;
		stuck_addr = '0;
		stuck_bit = '0;
		stuck_val = 1'b0;
		cur_line = "";
		prev_char = '0;
		clean_run();
		ready_after_busy();
		stuck_bit_report();
		access_discipline();
		back_pressure_repeat();
		$display("TESTS PASSED");
		$finish;
	end

endmodule
